// File: include/cluster_macros.svh
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Cluster sizing
`define NUM_SOCKETS         4
`define NUM_BARRIERS        8

// DCR bus widths
`define DCR_ADDR_W          12
`define DCR_DATA_W          32

// Half-open DCR address ranges
`define DCR_BASE_BEGIN      12'h001
`define DCR_BASE_END        12'h010
`define DCR_TEX_BEGIN       12'h010
`define DCR_TEX_END         12'h020
`define DCR_RASTER_BEGIN    12'h020
`define DCR_RASTER_END      12'h030
`define DCR_ROP_BEGIN       12'h030
`define DCR_ROP_END         12'h040

// Base state registers
`define DCR_STARTUP_ADDR    12'h001
`define DCR_STARTUP_ARG     12'h002
`define DCR_MPM_CLASS       12'h003

`endif

// File: design/cluster_pkg.sv
`default_nettype none

`include "cluster_macros.svh"

package cluster_pkg;

    // DCR bus payload
    typedef logic [`DCR_ADDR_W-1:0] dcr_addr_t;
    typedef logic [`DCR_DATA_W-1:0] dcr_data_t;

    // Barrier id, one entry per id in the barrier table
    typedef logic [$clog2(`NUM_BARRIERS)-1:0] gbar_id_t;

    // Socket index, also used for the barrier size minus one
    typedef logic [$clog2(`NUM_SOCKETS)-1:0] socket_idx_t;

    // One bit per socket
    typedef logic [`NUM_SOCKETS-1:0] socket_mask_t;

endpackage

`default_nettype wire

// File: design/dcr_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module dcr_router (
    input  wire                     clk,
    input  wire                     arst_n,

    // Host write
    input  wire                     dcr_wr_valid,
    input  cluster_pkg::dcr_addr_t  dcr_wr_addr,
    input  cluster_pkg::dcr_data_t  dcr_wr_data,

    // Registered per-region strobes
    output logic                    tex_dcr_valid,
    output logic                    raster_dcr_valid,
    output logic                    rop_dcr_valid,
    output logic                    base_wr_valid,
    output cluster_pkg::dcr_addr_t  unit_dcr_addr,
    output cluster_pkg::dcr_data_t  unit_dcr_data
);

    logic hit_base;
    logic hit_tex;
    logic hit_raster;
    logic hit_rop;

    // Range decode, ranges do not overlap
    always_comb begin
        hit_base   = dcr_wr_valid && (dcr_wr_addr >= `DCR_BASE_BEGIN)
                                  && (dcr_wr_addr <  `DCR_BASE_END);
        hit_tex    = dcr_wr_valid && (dcr_wr_addr >= `DCR_TEX_BEGIN)
                                  && (dcr_wr_addr <  `DCR_TEX_END);
        hit_raster = dcr_wr_valid && (dcr_wr_addr >= `DCR_RASTER_BEGIN)
                                  && (dcr_wr_addr <  `DCR_RASTER_END);
        hit_rop    = dcr_wr_valid && (dcr_wr_addr >= `DCR_ROP_BEGIN)
                                  && (dcr_wr_addr <  `DCR_ROP_END);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tex_dcr_valid    <= 1'b0;
            raster_dcr_valid <= 1'b0;
            rop_dcr_valid    <= 1'b0;
            base_wr_valid    <= 1'b0;
        end else begin
            tex_dcr_valid    <= hit_tex;
            raster_dcr_valid <= hit_raster;
            rop_dcr_valid    <= hit_rop;
            base_wr_valid    <= hit_base;
        end
    end

    // Shared payload, only loaded when some region matches
    always_ff @(posedge clk) begin
        if (hit_base || hit_tex || hit_raster || hit_rop) begin
            unit_dcr_addr <= dcr_wr_addr;
            unit_dcr_data <= dcr_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: design/base_dcr_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module base_dcr_regs (
    input  wire                     clk,
    input  wire                     arst_n,

    // Base-range write from the router
    input  wire                     base_wr_valid,
    input  cluster_pkg::dcr_addr_t  unit_dcr_addr,
    input  cluster_pkg::dcr_data_t  unit_dcr_data,

    // State read by the sockets at start
    output cluster_pkg::dcr_data_t  startup_addr,
    output cluster_pkg::dcr_data_t  startup_arg,
    output cluster_pkg::dcr_data_t  mpm_class
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            startup_addr <= '0;
            startup_arg  <= '0;
            mpm_class    <= '0;
        end else if (base_wr_valid) begin
            case (unit_dcr_addr)
                `DCR_STARTUP_ADDR: startup_addr <= unit_dcr_data;
                `DCR_STARTUP_ARG:  startup_arg  <= unit_dcr_data;
                `DCR_MPM_CLASS:    mpm_class    <= unit_dcr_data;
                // Rest of the base range is reserved
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/gbar_req_arb.sv
`timescale 1ns/1ns
`default_nettype none

module gbar_req_arb #(
    parameter int NUM_REQS = 4
) (
    input  wire                                     clk,
    input  wire                                     arst_n,

    // Per-socket request strobes
    input  wire  [NUM_REQS-1:0]                     req_valid,
    input  cluster_pkg::gbar_id_t    [NUM_REQS-1:0] req_id,
    input  cluster_pkg::socket_idx_t [NUM_REQS-1:0] req_size_m1,

    // Granted request, one per cycle
    output logic                                    arb_valid,
    output cluster_pkg::gbar_id_t                   arb_id,
    output cluster_pkg::socket_idx_t                arb_size_m1,
    output cluster_pkg::socket_idx_t                arb_socket,
    output logic                                    pending_any
);

    logic [NUM_REQS-1:0]                     slot_valid;
    cluster_pkg::gbar_id_t    [NUM_REQS-1:0] slot_id;
    cluster_pkg::socket_idx_t [NUM_REQS-1:0] slot_size_m1;

    logic [NUM_REQS-1:0]                     cand_valid;
    cluster_pkg::gbar_id_t    [NUM_REQS-1:0] cand_id;
    cluster_pkg::socket_idx_t [NUM_REQS-1:0] cand_size_m1;

    cluster_pkg::socket_idx_t last_grant;
    cluster_pkg::socket_idx_t grant_idx;
    logic                     grant_found;

    // A fresh strobe is eligible in its own cycle
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            cand_valid[i]   = slot_valid[i] | req_valid[i];
            cand_id[i]      = req_valid[i] ? req_id[i] : slot_id[i];
            cand_size_m1[i] = req_valid[i] ? req_size_m1[i] : slot_size_m1[i];
        end
    end

    // Round-robin search starting after the last grant
    always_comb begin : grant_search
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 1; k <= NUM_REQS; k++) begin
            idx = (int'(last_grant) + k) % NUM_REQS;
            if (!grant_found && cand_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = cluster_pkg::socket_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
            last_grant <= cluster_pkg::socket_idx_t'(NUM_REQS - 1);
            arb_valid  <= 1'b0;
        end else begin
            slot_valid <= cand_valid;
            if (grant_found) begin
                slot_valid[grant_idx] <= 1'b0;
                last_grant            <= grant_idx;
            end
            arb_valid <= grant_found;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REQS; i++) begin
            if (req_valid[i]) begin
                slot_id[i]      <= req_id[i];
                slot_size_m1[i] <= req_size_m1[i];
            end
        end
        if (grant_found) begin
            arb_id      <= cand_id[grant_idx];
            arb_size_m1 <= cand_size_m1[grant_idx];
            arb_socket  <= grant_idx;
        end
    end

    // Output register counts as in flight
    assign pending_any = (|slot_valid) | arb_valid;

endmodule

`default_nettype wire

// File: design/gbar_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module gbar_unit (
    input  wire                         clk,
    input  wire                         arst_n,

    // Granted arrival from the arbiter
    input  wire                         arb_valid,
    input  cluster_pkg::gbar_id_t       arb_id,
    input  cluster_pkg::socket_idx_t    arb_size_m1,
    input  cluster_pkg::socket_idx_t    arb_socket,
    input  wire                         pending_any,

    // Release broadcast to all sockets
    output logic                        gbar_rel_valid,
    output cluster_pkg::gbar_id_t       gbar_rel_id,
    output logic                        gbar_busy
);

    localparam int CNT_W = $clog2(`NUM_SOCKETS + 1);

    cluster_pkg::socket_mask_t arrive_mask [`NUM_BARRIERS];
    cluster_pkg::socket_mask_t next_mask;
    logic [CNT_W-1:0]          arrive_cnt;
    logic                      complete;
    logic                      any_partial;

    // Arrivals for the granted id including this one
    always_comb begin
        next_mask  = arrive_mask[arb_id] | (cluster_pkg::socket_mask_t'(1) << arb_socket);
        arrive_cnt = '0;
        for (int i = 0; i < `NUM_SOCKETS; i++) begin
            arrive_cnt = arrive_cnt + CNT_W'(next_mask[i]);
        end
        complete = arb_valid && (arrive_cnt == CNT_W'(arb_size_m1) + CNT_W'(1));
    end

    always_comb begin
        any_partial = 1'b0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            any_partial = any_partial | (|arrive_mask[b]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                arrive_mask[b] <= '0;
            end
            gbar_rel_valid <= 1'b0;
        end else begin
            if (arb_valid) begin
                // Completed entry is free for reuse next cycle
                arrive_mask[arb_id] <= complete ? '0 : next_mask;
            end
            gbar_rel_valid <= complete;
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            gbar_rel_id <= arb_id;
        end
    end

    assign gbar_busy = any_partial | pending_any;

endmodule

`default_nettype wire

// File: design/cluster_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_ctrl (
    input  wire                                         clk,
    input  wire                                         arst_n,

    // Host DCR write
    input  wire                                         dcr_wr_valid,
    input  cluster_pkg::dcr_addr_t                      dcr_wr_addr,
    input  cluster_pkg::dcr_data_t                      dcr_wr_data,

    // Socket barrier requests
    input  wire  [`NUM_SOCKETS-1:0]                     gbar_req_valid,
    input  cluster_pkg::gbar_id_t    [`NUM_SOCKETS-1:0] gbar_req_id,
    input  cluster_pkg::socket_idx_t [`NUM_SOCKETS-1:0] gbar_req_size_m1,

    // Unit DCR strobes
    output logic                                        tex_dcr_valid,
    output logic                                        raster_dcr_valid,
    output logic                                        rop_dcr_valid,
    output cluster_pkg::dcr_addr_t                      unit_dcr_addr,
    output cluster_pkg::dcr_data_t                      unit_dcr_data,

    // Base state
    output cluster_pkg::dcr_data_t                      startup_addr,
    output cluster_pkg::dcr_data_t                      startup_arg,
    output cluster_pkg::dcr_data_t                      mpm_class,

    // Barrier release and status
    output logic                                        gbar_rel_valid,
    output cluster_pkg::gbar_id_t                       gbar_rel_id,
    output logic                                        gbar_busy
);

    logic                     base_wr_valid;
    logic                     arb_valid;
    cluster_pkg::gbar_id_t    arb_id;
    cluster_pkg::socket_idx_t arb_size_m1;
    cluster_pkg::socket_idx_t arb_socket;
    logic                     pending_any;

    //********************************************************************
    // DCR path
    //********************************************************************

    dcr_router dcr_router_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .dcr_wr_valid     (dcr_wr_valid),
        .dcr_wr_addr      (dcr_wr_addr),
        .dcr_wr_data      (dcr_wr_data),
        .tex_dcr_valid    (tex_dcr_valid),
        .raster_dcr_valid (raster_dcr_valid),
        .rop_dcr_valid    (rop_dcr_valid),
        .base_wr_valid    (base_wr_valid),
        .unit_dcr_addr    (unit_dcr_addr),
        .unit_dcr_data    (unit_dcr_data)
    );

    base_dcr_regs base_dcr_regs_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .base_wr_valid (base_wr_valid),
        .unit_dcr_addr (unit_dcr_addr),
        .unit_dcr_data (unit_dcr_data),
        .startup_addr  (startup_addr),
        .startup_arg   (startup_arg),
        .mpm_class     (mpm_class)
    );

    //********************************************************************
    // Barrier path
    //********************************************************************

    gbar_req_arb #(
        .NUM_REQS (`NUM_SOCKETS)
    ) gbar_req_arb_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (gbar_req_valid),
        .req_id      (gbar_req_id),
        .req_size_m1 (gbar_req_size_m1),
        .arb_valid   (arb_valid),
        .arb_id      (arb_id),
        .arb_size_m1 (arb_size_m1),
        .arb_socket  (arb_socket),
        .pending_any (pending_any)
    );

    gbar_unit gbar_unit_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .arb_valid      (arb_valid),
        .arb_id         (arb_id),
        .arb_size_m1    (arb_size_m1),
        .arb_socket     (arb_socket),
        .pending_any    (pending_any),
        .gbar_rel_valid (gbar_rel_valid),
        .gbar_rel_id    (gbar_rel_id),
        .gbar_busy      (gbar_busy)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cluster_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module tb_cluster_ctrl;

    localparam int          CLK_PERIOD        = 8;
    localparam int          TIMEOUT_CYCLES    = 200;
    localparam int          NUM_RANDOM_WRITES = 300;
    localparam int          NS                = `NUM_SOCKETS;
    localparam logic [31:0] RAND_SEED         = 32'h5e800a63;

    logic                                          clk;
    logic                                          arst_n;
    logic                                          dcr_wr_valid;
    cluster_pkg::dcr_addr_t                        dcr_wr_addr;
    cluster_pkg::dcr_data_t                        dcr_wr_data;
    logic [NS-1:0]                                 gbar_req_valid;
    cluster_pkg::gbar_id_t    [NS-1:0]             gbar_req_id;
    cluster_pkg::socket_idx_t [NS-1:0]             gbar_req_size_m1;
    logic                                          tex_dcr_valid;
    logic                                          raster_dcr_valid;
    logic                                          rop_dcr_valid;
    cluster_pkg::dcr_addr_t                        unit_dcr_addr;
    cluster_pkg::dcr_data_t                        unit_dcr_data;
    cluster_pkg::dcr_data_t                        startup_addr;
    cluster_pkg::dcr_data_t                        startup_arg;
    cluster_pkg::dcr_data_t                        mpm_class;
    logic                                          gbar_rel_valid;
    cluster_pkg::gbar_id_t                         gbar_rel_id;
    logic                                          gbar_busy;

    int mismatch_count = 0;
    int timeout_count  = 0;

    // Expected unit writes as {addr, data} in arrival order
    logic [`DCR_ADDR_W+`DCR_DATA_W-1:0] unit_q [$];

    // Barrier model
    cluster_pkg::socket_mask_t model_mask [`NUM_BARRIERS];
    cluster_pkg::socket_idx_t  model_size [`NUM_BARRIERS];
    logic                      model_busy;

    // Per-socket plan for one barrier round
    cluster_pkg::gbar_id_t    plan_id    [NS];
    cluster_pkg::socket_idx_t plan_size  [NS];
    int                       plan_delay [NS];

    cluster_ctrl dut_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .dcr_wr_valid     (dcr_wr_valid),
        .dcr_wr_addr      (dcr_wr_addr),
        .dcr_wr_data      (dcr_wr_data),
        .gbar_req_valid   (gbar_req_valid),
        .gbar_req_id      (gbar_req_id),
        .gbar_req_size_m1 (gbar_req_size_m1),
        .tex_dcr_valid    (tex_dcr_valid),
        .raster_dcr_valid (raster_dcr_valid),
        .rop_dcr_valid    (rop_dcr_valid),
        .unit_dcr_addr    (unit_dcr_addr),
        .unit_dcr_data    (unit_dcr_data),
        .startup_addr     (startup_addr),
        .startup_arg      (startup_arg),
        .mpm_class        (mpm_class),
        .gbar_rel_valid   (gbar_rel_valid),
        .gbar_rel_id      (gbar_rel_id),
        .gbar_busy        (gbar_busy)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic in_range(input cluster_pkg::dcr_addr_t addr,
                                      input cluster_pkg::dcr_addr_t lo,
                                      input cluster_pkg::dcr_addr_t hi);
        return (addr >= lo) && (addr < hi);
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH %0t: %s", $time, msg);
    endtask

    always_comb begin
        model_busy = 1'b0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            model_busy = model_busy | (|model_mask[b]);
        end
    end

    //**********************************************************************
    // Concurrent checks
    //**********************************************************************

    reset_low_a: assert property (@(posedge clk) !arst_n |->
        !(tex_dcr_valid || raster_dcr_valid || rop_dcr_valid || gbar_rel_valid || gbar_busy))
        else report_mismatch("strobe or busy high during reset");

    tex_route_a: assert property (@(posedge clk) disable iff (!arst_n)
        tex_dcr_valid == ($past(dcr_wr_valid)
            && in_range($past(dcr_wr_addr), `DCR_TEX_BEGIN, `DCR_TEX_END)))
        else report_mismatch("texture strobe does not follow the write");

    raster_route_a: assert property (@(posedge clk) disable iff (!arst_n)
        raster_dcr_valid == ($past(dcr_wr_valid)
            && in_range($past(dcr_wr_addr), `DCR_RASTER_BEGIN, `DCR_RASTER_END)))
        else report_mismatch("raster strobe does not follow the write");

    rop_route_a: assert property (@(posedge clk) disable iff (!arst_n)
        rop_dcr_valid == ($past(dcr_wr_valid)
            && in_range($past(dcr_wr_addr), `DCR_ROP_BEGIN, `DCR_ROP_END)))
        else report_mismatch("ROP strobe does not follow the write");

    one_strobe_a: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({tex_dcr_valid, raster_dcr_valid, rop_dcr_valid}))
        else report_mismatch("more than one unit strobe high");

    unit_payload_a: assert property (@(posedge clk) disable iff (!arst_n)
        (tex_dcr_valid || raster_dcr_valid || rop_dcr_valid) |->
            (unit_dcr_addr == $past(dcr_wr_addr) && unit_dcr_data == $past(dcr_wr_data)))
        else report_mismatch("unit address or data differs from the write");

    // Base registers load two cycles after the host write and hold otherwise
    startup_addr_a: assert property (@(posedge clk) disable iff (!arst_n)
        $past(dcr_wr_valid && dcr_wr_addr == `DCR_STARTUP_ADDR, 2)
            ? startup_addr == $past(dcr_wr_data, 2) : $stable(startup_addr))
        else report_mismatch("startup_addr wrong");

    startup_arg_a: assert property (@(posedge clk) disable iff (!arst_n)
        $past(dcr_wr_valid && dcr_wr_addr == `DCR_STARTUP_ARG, 2)
            ? startup_arg == $past(dcr_wr_data, 2) : $stable(startup_arg))
        else report_mismatch("startup_arg wrong");

    mpm_class_a: assert property (@(posedge clk) disable iff (!arst_n)
        $past(dcr_wr_valid && dcr_wr_addr == `DCR_MPM_CLASS, 2)
            ? mpm_class == $past(dcr_wr_data, 2) : $stable(mpm_class))
        else report_mismatch("mpm_class wrong");

    busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        (model_busy && !gbar_rel_valid) |-> gbar_busy)
        else report_mismatch("gbar_busy low with an incomplete barrier");

    //**********************************************************************
    // Reference models
    //**********************************************************************

    always @(posedge clk) begin : track_model
        cluster_pkg::gbar_id_t rid;
        if (!arst_n) begin
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                model_mask[b] = '0;
                model_size[b] = '0;
            end
        end else begin
            if (tex_dcr_valid || raster_dcr_valid || rop_dcr_valid) begin
                write_outstanding_a: assert (unit_q.size() != 0)
                    else report_mismatch("unit strobe with no write outstanding");
                if (unit_q.size() != 0) begin
                    unit_write_a: assert (unit_q[0] == {unit_dcr_addr, unit_dcr_data})
                        else report_mismatch($sformatf("unit write %h/%h, expected %h",
                            unit_dcr_addr, unit_dcr_data, unit_q[0]));
                    void'(unit_q.pop_front());
                end
            end
            if (gbar_rel_valid) begin
                rid = gbar_rel_id;
                release_a: assert ($countones(model_mask[rid]) == int'(model_size[rid]) + 1)
                    else report_mismatch($sformatf("release of id %0d after %0d arrivals",
                        rid, $countones(model_mask[rid])));
                model_mask[rid] = '0;
            end
            for (int s = 0; s < NS; s++) begin
                if (gbar_req_valid[s]) begin
                    rid             = gbar_req_id[s];
                    model_mask[rid] = model_mask[rid] | (cluster_pkg::socket_mask_t'(1) << s);
                    model_size[rid] = gbar_req_size_m1[s];
                end
            end
        end
    end

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        base_zero_a: assert (startup_addr == '0 && startup_arg == '0 && mpm_class == '0)
            else report_mismatch("base registers not zero in reset");
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        after_reset_a: assert (!tex_dcr_valid && !raster_dcr_valid && !rop_dcr_valid
            && !gbar_rel_valid && !gbar_busy && startup_addr == '0)
            else report_mismatch("outputs not idle right after reset");
    endtask

    task automatic write_dcr(input cluster_pkg::dcr_addr_t addr,
                             input cluster_pkg::dcr_data_t data);
        @(posedge clk);
        dcr_wr_valid <= 1'b1;
        dcr_wr_addr  <= addr;
        dcr_wr_data  <= data;
        if (in_range(addr, `DCR_TEX_BEGIN, `DCR_ROP_END)) begin
            unit_q.push_back({addr, data});
        end
    endtask

    task automatic idle_dcr();
        @(posedge clk);
        dcr_wr_valid <= 1'b0;
    endtask

    task automatic wait_dcr_drain();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (unit_q.size() != 0 && cycles < TIMEOUT_CYCLES);
        if (unit_q.size() != 0) begin
            timeout_count++;
            $display("Timed out at %0t: %0d unit writes never arrived", $time, unit_q.size());
        end
    endtask

    task automatic wait_barrier_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((model_busy || gbar_busy) && cycles < TIMEOUT_CYCLES);
        if (model_busy || gbar_busy) begin
            timeout_count++;
            $display("Timed out at %0t waiting for barriers to release and busy to drop",
                     $time);
        end
    endtask

    task automatic run_barrier_round();
        int last_delay;
        last_delay = 0;
        for (int s = 0; s < NS; s++) begin
            if (plan_delay[s] > last_delay) begin
                last_delay = plan_delay[s];
            end
        end
        for (int c = 0; c <= last_delay; c++) begin
            @(posedge clk);
            for (int s = 0; s < NS; s++) begin
                gbar_req_valid[s]   <= (plan_delay[s] == c);
                gbar_req_id[s]      <= plan_id[s];
                gbar_req_size_m1[s] <= plan_size[s];
            end
        end
        @(posedge clk);
        gbar_req_valid <= '0;
        wait_barrier_idle();
    endtask

    //**********************************************************************
    // Stimulus
    //**********************************************************************

    initial begin : main
        int                    seed_ret;
        cluster_pkg::gbar_id_t id_a;
        cluster_pkg::gbar_id_t id_b;
        seed_ret         = $urandom(RAND_SEED);
        dcr_wr_valid     = 1'b0;
        dcr_wr_addr      = '0;
        dcr_wr_data      = '0;
        gbar_req_valid   = '0;
        gbar_req_id      = '0;
        gbar_req_size_m1 = '0;
        apply_reset();

        // Random routing across all ranges and past them
        repeat (NUM_RANDOM_WRITES) begin
            if ($urandom_range(3, 0) != 0) begin
                write_dcr(cluster_pkg::dcr_addr_t'($urandom_range(12'h04F, 0)), $urandom);
            end else begin
                idle_dcr();
            end
        end

        // Named base registers then reserved base addresses and a back-to-back rewrite
        write_dcr(`DCR_STARTUP_ADDR, $urandom);
        write_dcr(`DCR_STARTUP_ARG, $urandom);
        write_dcr(`DCR_MPM_CLASS, $urandom);
        for (int a = 4; a < 16; a++) begin
            write_dcr(cluster_pkg::dcr_addr_t'(a), $urandom);
        end
        write_dcr(`DCR_STARTUP_ADDR, $urandom);
        write_dcr(`DCR_STARTUP_ADDR, $urandom);
        idle_dcr();
        wait_dcr_drain();

        // Full barriers with all sockets at random cycles
        repeat (3) begin
            id_a = cluster_pkg::gbar_id_t'($urandom_range(`NUM_BARRIERS - 1, 0));
            for (int s = 0; s < NS; s++) begin
                plan_id[s]    = id_a;
                plan_size[s]  = cluster_pkg::socket_idx_t'(NS - 1);
                plan_delay[s] = $urandom_range(12, 0);
            end
            run_barrier_round();
        end

        // Two pairs on two ids with all strobes in one cycle first and spread out later
        for (int round = 0; round < 4; round++) begin
            id_a = cluster_pkg::gbar_id_t'($urandom_range(`NUM_BARRIERS - 1, 0));
            id_b = id_a + cluster_pkg::gbar_id_t'($urandom_range(`NUM_BARRIERS - 1, 1));
            for (int s = 0; s < NS; s++) begin
                plan_id[s]    = ((round % 2 == 0) ? (s < 2) : (s % 2 == 0)) ? id_a : id_b;
                plan_size[s]  = cluster_pkg::socket_idx_t'(1);
                plan_delay[s] = (round == 0) ? 0 : $urandom_range(6, 0);
            end
            run_barrier_round();
        end

        $display("Error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
design/cluster_pkg.sv
design/dcr_router.sv
design/base_dcr_regs.sv
design/gbar_req_arb.sv
design/gbar_unit.sv
design/cluster_ctrl.sv
testbench/tb_cluster_ctrl.sv
